// ==== common/pkt_pkg.sv ====
//====================================================================
// packet format used on every port of the mesh node
// node address is {y, x}, each axis COORD_W bits wide
// pkt_type is carried through the node and never decoded
//====================================================================
package pkt_pkg;

    localparam int COORD_W   = 3;
    localparam int NODE_ID_W = 2 * COORD_W;
    localparam int TYPE_W    = 2;
    localparam int DATA_W    = 8;

    typedef logic [COORD_W-1:0]   coord_t;     // one axis
    typedef logic [NODE_ID_W-1:0] node_id_t;   // y high, x low
    typedef logic                 qos_t;       // 1 = high priority
    typedef logic [TYPE_W-1:0]    pkt_type_t;
    typedef logic [DATA_W-1:0]    data_t;

    // 23 bits, qos on top
    typedef struct packed {
        qos_t      qos;
        pkt_type_t pkt_type;
        node_id_t  src;
        node_id_t  tgt;
        data_t     data;
    } pkt_t;

endpackage

// ==== common/route_pkg.sv ====
//====================================================================
// port numbering of the node and per-port vectors
// port order N, W, S, E, then L (local inject / deliver)
//====================================================================
package route_pkg;

    import pkt_pkg::*;

    localparam int NUM_PORTS  = 5;
    localparam int PORT_IDX_W = 3;

    typedef logic [PORT_IDX_W-1:0] dir_t;

    // port indices
    localparam dir_t DIR_N = 3'd0;
    localparam dir_t DIR_W = 3'd1;
    localparam dir_t DIR_S = 3'd2;
    localparam dir_t DIR_E = 3'd3;
    localparam dir_t DIR_L = 3'd4;    // local port

    // one bit per port indexed by dir_t
    typedef logic [NUM_PORTS-1:0] port_vec_t;

    // one packet per port (115 bits)
    typedef pkt_t [NUM_PORTS-1:0] pkt_arr_t;

endpackage

// ==== router/crossbar.sv ====
//====================================================================
// per-output request gathering, arbitration and payload select
// an output only arbitrates while its output buffer is ready, so a
// grant is always a transfer; no output sees its own direction
//====================================================================
`timescale 1ns/10ps

module crossbar
    import pkt_pkg::*, route_pkg::*;
(
    input  port_vec_t                  hold_vld_i,
    input  pkt_arr_t                   hold_pkt_i,
    input  port_vec_t [NUM_PORTS-1:0]  route_i,     // [input][output]
    input  port_vec_t                  obuf_rdy_i,
    output port_vec_t                  gnt_o,       // per input
    output wire port_vec_t             load_o,      // per output
    output wire pkt_arr_t              sel_pkt_o
);

    // local output sees all five inputs, mesh outputs four
    function automatic int arb_width(input int out_d);
        return (out_d == DIR_L) ? NUM_PORTS : NUM_PORTS - 1;
    endfunction

    // input feeding arbiter bit slot: L on top, then N, W, S, E
    function automatic int src_dir(input int out_d, input int slot, input int width);
        int seen;
        int res;
        seen = 0;
        res  = DIR_L;
        if (slot != width - 1) begin
            for (int m = 0; m < DIR_L; m++) begin
                if (m != out_d) begin
                    if (seen == width - 2 - slot) begin
                        res = m;
                    end
                    seen++;
                end
            end
        end
        return res;
    endfunction

    port_vec_t gnt_map [NUM_PORTS];   // [output] -> inputs granted

    //==================================================================
    // one arbiter per output
    //==================================================================
    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
        logic [arb_width(o)-1:0] req;
        logic [arb_width(o)-1:0] qos;
        logic [arb_width(o)-1:0] gnt;
        pkt_t                    sel;

        always_comb begin
            for (int k = 0; k < arb_width(o); k++) begin
                req[k] = hold_vld_i[src_dir(o, k, arb_width(o))]
                       & route_i[src_dir(o, k, arb_width(o))][o]
                       & obuf_rdy_i[o];   // full output stays out
                qos[k] = hold_pkt_i[src_dir(o, k, arb_width(o))].qos;
            end
        end

        qos_arbiter #(
            .WIDTH (arb_width(o))
        ) u_arb (
            .req_i (req),
            .qos_i (qos),
            .gnt_o (gnt)
        );

        // winner payload and grant back to its input
        always_comb begin
            sel        = '0;
            gnt_map[o] = '0;
            for (int k = 0; k < arb_width(o); k++) begin
                if (gnt[k]) begin
                    sel = hold_pkt_i[src_dir(o, k, arb_width(o))];
                end
                gnt_map[o][src_dir(o, k, arb_width(o))] = gnt[k];
            end
        end

        assign sel_pkt_o[o] = sel;
        assign load_o[o]    = |gnt;
    end

    // fold to one grant bit per input
    always_comb begin
        gnt_o = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            gnt_o = gnt_o | gnt_map[o];
        end
    end

endmodule

// ==== router/input_buf.sv ====
//====================================================================
// one-entry input buffer
// ready is high when empty or when the held packet is granted this
// cycle, so back-to-back packets pass at one per cycle
//====================================================================
`timescale 1ns/10ps

module input_buf
    import pkt_pkg::*;
(
    input  logic clk,
    input  logic reset_i,
    input  logic vld_i,
    input  pkt_t pkt_i,
    output logic rdy_o,
    input  logic gnt_i,        // any grant to this input
    output logic hold_vld_o,
    output pkt_t hold_pkt_o
);

    logic hold_vld_q;
    pkt_t hold_pkt_q;
    logic load;

    assign rdy_o = ~hold_vld_q | gnt_i;
    assign load  = vld_i & rdy_o;

    // valid flag
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hold_vld_q <= 1'b0;
        end else if (load) begin
            hold_vld_q <= 1'b1;
        end else if (gnt_i) begin
            hold_vld_q <= 1'b0;     // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hold_pkt_q <= pkt_i;
        end
    end

    assign hold_vld_o = hold_vld_q;
    assign hold_pkt_o = hold_pkt_q;

endmodule

// ==== router/output_buf.sv ====
//====================================================================
// registered output stage with valid/ready
// load strobe is trusted, crossbar only loads while rdy_o is high
//====================================================================
`timescale 1ns/10ps

module output_buf
    import pkt_pkg::*;
(
    input  logic clk,
    input  logic reset_i,
    input  logic load_i,
    input  pkt_t pkt_i,
    output logic rdy_o,        // toward crossbar
    output logic vld_o,
    output pkt_t pkt_o,
    input  logic rdy_i         // from downstream
);

    logic vld_q;
    pkt_t pkt_q;

    // free next edge if empty or being taken now
    assign rdy_o = ~vld_q | rdy_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vld_q <= 1'b0;
        end else if (load_i) begin
            vld_q <= 1'b1;
        end else if (rdy_i) begin
            vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            pkt_q <= pkt_i;   // held stable while stalled
        end
    end

    assign vld_o = vld_q;
    assign pkt_o = pkt_q;

endmodule

// ==== router/qos_arbiter.sv ====
//====================================================================
// combinational QoS-first fixed-order arbiter
// qos requesters win first, then the highest index wins
// caller maps its preferred port onto the top bit
//====================================================================
`timescale 1ns/10ps

module qos_arbiter #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] req_i,
    input  logic [WIDTH-1:0] qos_i,
    output logic [WIDTH-1:0] gnt_o    // one-hot or zero
);

    logic [WIDTH-1:0] hi_req;
    logic [WIDTH-1:0] cand;

    assign hi_req = req_i & qos_i;

    // qos class wins whenever anyone in it is asking
    assign cand = (|hi_req) ? hi_req : req_i;

    // scan upward, last hit is the highest index
    always_comb begin
        gnt_o = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (cand[i]) begin
                gnt_o    = '0;
                gnt_o[i] = 1'b1;
            end
        end
    end

endmodule

// ==== router/xy_route.sv ====
//====================================================================
// XY route decision for one input, x first then y
// no edge checks, packets leaving the mesh are the sender's problem
// request is not qualified by valid
//====================================================================
`timescale 1ns/10ps

module xy_route
    import pkt_pkg::*, route_pkg::*;
#(
    parameter int NODE_X = 0,
    parameter int NODE_Y = 0
) (
    input  node_id_t  tgt_i,
    output port_vec_t route_o     // one-hot
);

    coord_t tgt_x;
    coord_t tgt_y;

    assign tgt_x = tgt_i[COORD_W-1:0];
    assign tgt_y = tgt_i[2*COORD_W-1:COORD_W];

    always_comb begin
        route_o = '0;
        if (tgt_x > coord_t'(NODE_X)) begin
            route_o[DIR_E] = 1'b1;
        end else if (tgt_x < coord_t'(NODE_X)) begin
            route_o[DIR_W] = 1'b1;
        end else if (tgt_y > coord_t'(NODE_Y)) begin
            route_o[DIR_N] = 1'b1;  // x done, now y
        end else if (tgt_y < coord_t'(NODE_Y)) begin
            route_o[DIR_S] = 1'b1;
        end else begin
            route_o[DIR_L] = 1'b1;  // arrived
        end
    end

endmodule

// ==== testbench/tb_vectors.svh ====
//======================================================================
// stimulus table for the mesh node testbench, node sits at (3,3)
// columns: name, input port, qos, type, src, tgt, partner, stall, exp port
// partner pairs an entry with the next one in the same cycle
// stall is the number of cycles out_rdy_i stays low, taken from the first entry
//======================================================================

localparam int NUM_VEC = 20;

typedef struct packed {
    dir_t       in_port;
    pkt_t       pkt;
    logic       partner;
    logic [3:0] stall;
    dir_t       exp_port;
} vec_t;

vec_t  vec_tab  [NUM_VEC];
string vec_name [NUM_VEC];
int    vec_cnt;

function automatic node_id_t node_at(input int x, input int y);
    return {coord_t'(y), coord_t'(x)};
endfunction

task automatic add_vec(input string name, input dir_t in_port, input qos_t qos,
                       input pkt_type_t typ, input node_id_t src, input node_id_t tgt,
                       input logic partner, input int stall, input dir_t exp_port);
    vec_name[vec_cnt]              = name;
    vec_tab[vec_cnt].in_port       = in_port;
    vec_tab[vec_cnt].pkt.qos       = qos;
    vec_tab[vec_cnt].pkt.pkt_type  = typ;
    vec_tab[vec_cnt].pkt.src       = src;
    vec_tab[vec_cnt].pkt.tgt       = tgt;
    vec_tab[vec_cnt].pkt.data      = data_t'($random(seed));
    vec_tab[vec_cnt].partner       = partner;
    vec_tab[vec_cnt].stall         = 4'(stall);
    vec_tab[vec_cnt].exp_port      = exp_port;
    vec_cnt++;
endtask

task automatic build_table();
    vec_cnt = 0;
    // local injection, one per direction
    add_vec("loc_east",  DIR_L, 1'b0, 2'd0, node_at(3, 3), node_at(5, 3), 1'b0, 0, DIR_E);
    add_vec("loc_west",  DIR_L, 1'b1, 2'd1, node_at(3, 3), node_at(1, 3), 1'b0, 0, DIR_W);
    add_vec("loc_north", DIR_L, 1'b0, 2'd2, node_at(3, 3), node_at(3, 6), 1'b0, 0, DIR_N);
    add_vec("loc_south", DIR_L, 1'b1, 2'd3, node_at(3, 3), node_at(3, 0), 1'b0, 0, DIR_S);
    add_vec("loc_local", DIR_L, 1'b0, 2'd1, node_at(3, 3), node_at(3, 3), 1'b0, 0, DIR_L);
    // forwarding from the mesh ports
    add_vec("n_south",   DIR_N, 1'b0, 2'd0, node_at(3, 4), node_at(3, 1), 1'b0, 0, DIR_S);
    add_vec("n_local",   DIR_N, 1'b1, 2'd2, node_at(3, 4), node_at(3, 3), 1'b0, 0, DIR_L);
    add_vec("w_east",    DIR_W, 1'b0, 2'd3, node_at(2, 3), node_at(6, 2), 1'b0, 0, DIR_E);
    add_vec("w_local",   DIR_W, 1'b0, 2'd1, node_at(2, 3), node_at(3, 3), 1'b0, 0, DIR_L);
    add_vec("s_north",   DIR_S, 1'b1, 2'd0, node_at(3, 2), node_at(3, 5), 1'b0, 0, DIR_N);
    add_vec("s_local",   DIR_S, 1'b0, 2'd2, node_at(3, 2), node_at(3, 3), 1'b0, 0, DIR_L);
    add_vec("e_west",    DIR_E, 1'b0, 2'd3, node_at(4, 3), node_at(0, 4), 1'b0, 0, DIR_W);
    add_vec("e_local",   DIR_E, 1'b1, 2'd0, node_at(4, 3), node_at(3, 3), 1'b0, 0, DIR_L);
    // contention, qos beats port order
    add_vec("qos_w",     DIR_W, 1'b0, 2'd1, node_at(2, 3), node_at(5, 3), 1'b1, 0, DIR_E);
    add_vec("qos_s",     DIR_S, 1'b1, 2'd2, node_at(3, 2), node_at(7, 3), 1'b0, 0, DIR_E);
    // contention, equal qos
    add_vec("tie_n",     DIR_N, 1'b0, 2'd3, node_at(3, 4), node_at(6, 3), 1'b1, 0, DIR_E);
    add_vec("tie_l",     DIR_L, 1'b0, 2'd0, node_at(3, 3), node_at(4, 3), 1'b0, 0, DIR_E);
    // back-pressure on the south output
    add_vec("stall_w",   DIR_W, 1'b1, 2'd2, node_at(2, 3), node_at(3, 2), 1'b1, 5, DIR_S);
    add_vec("stall_e",   DIR_E, 1'b1, 2'd1, node_at(4, 3), node_at(3, 0), 1'b0, 5, DIR_S);
    add_vec("stall_loc", DIR_L, 1'b0, 2'd3, node_at(3, 3), node_at(1, 3), 1'b0, 4, DIR_W);
endtask

// ==== testbench/tb_mesh_node.sv ====
//======================================================================
// testbench for one mesh node at (3,3)
// packets are applied one group at a time
// each group is one entry or a pair
// the run is bounded by a cycle counter
//======================================================================
`timescale 1ns/10ps

module tb_mesh_node
    import pkt_pkg::*, route_pkg::*;
();

    logic      clk;
    logic      reset_i;
    port_vec_t in_vld_i;
    pkt_arr_t  in_pkt_i;
    port_vec_t in_rdy_o;
    port_vec_t out_vld_o;
    pkt_arr_t  out_pkt_o;
    port_vec_t out_rdy_i;

    integer seed;
    int     cyc = 0;
    int     err_cnt;
    int     chk_cnt;
    string  cur_test;

    `include "tb_vectors.svh"

    localparam int MAX_CYC = 16 + 20 * NUM_VEC;

    mesh_node #(
        .NODE_X (3),
        .NODE_Y (3)
    ) i_mesh_node (
        .clk       (clk),
        .reset_i   (reset_i),
        .in_vld_i  (in_vld_i),
        .in_pkt_i  (in_pkt_i),
        .in_rdy_o  (in_rdy_o),
        .out_vld_o (out_vld_o),
        .out_pkt_o (out_pkt_o),
        .out_rdy_i (out_rdy_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYC) begin
            $display("timeout after %0d cycles, no delivery for test %s", cyc, cur_test);
            $display("checks: %0d, errors: %0d", chk_cnt, err_cnt + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    //==================================================================
    // compare tasks
    //==================================================================
    task automatic check_pkt(input string name, input pkt_t exp, input pkt_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_port(input string name, input dir_t exp, input dir_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s: expected port %0d, actual port %0d", name, exp, act);
        end
    endtask

    task automatic check_vec(input string name, input port_vec_t exp, input port_vec_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_lat(input string name, input int exp, input int act);
        chk_cnt++;
        if (act != exp) begin
            err_cnt++;
            $display("ERR %s: expected latency %0d, actual %0d", name, exp, act);
        end
    endtask

    // tie order L, N, W, S, E
    function automatic int arb_rank(input dir_t d);
        return (d == DIR_L) ? 0 : int'(d) + 1;
    endfunction

    function automatic logic beats(input vec_t a, input vec_t b);
        if (a.pkt.qos != b.pkt.qos) begin
            return a.pkt.qos;
        end
        return arb_rank(a.in_port) < arb_rank(b.in_port);
    endfunction

    function automatic dir_t first_port(input port_vec_t v);
        dir_t res;
        res = DIR_L;
        for (int d = NUM_PORTS - 1; d >= 0; d--) begin
            if (v[d]) res = dir_t'(d);
        end
        return res;
    endfunction

    //==================================================================
    // stimulus
    //==================================================================
    initial begin
        pkt_t      exp_q [$];
        pkt_t      held;
        port_vec_t acc;
        port_vec_t rdy_exp;
        dir_t      e;
        int        i;
        int        n;
        int        w;
        int        l;
        int        stall;
        int        xfer_cyc;

        seed      = 32'h58a;
        err_cnt   = 0;
        chk_cnt   = 0;
        cur_test  = "reset";
        reset_i   = 1'b1;
        in_vld_i  = '0;
        in_pkt_i  = '0;
        out_rdy_i = '1;
        xfer_cyc  = 0;
        build_table();

        repeat (16) begin
            @(posedge clk);
            #1;
            check_vec("reset_out_vld", '0, out_vld_o);
            check_vec("reset_in_rdy", '1, in_rdy_o);
        end
        reset_i = 1'b0;

        i = 0;
        while (i < NUM_VEC) begin
            n        = vec_tab[i].partner ? 2 : 1;
            cur_test = vec_name[i];
            e        = vec_tab[i].exp_port;
            stall    = vec_tab[i].stall;
            w        = (n == 2 && beats(vec_tab[i + 1], vec_tab[i])) ? i + 1 : i;
            l        = (w == i) ? i + 1 : i;    // loser of a pair
            exp_q.delete();
            exp_q.push_back(vec_tab[w].pkt);
            if (n == 2) exp_q.push_back(vec_tab[l].pkt);

            @(posedge clk);
            #1;
            out_rdy_i = '1;
            if (stall > 0) out_rdy_i[e] = 1'b0;
            for (int k = 0; k < n; k++) begin
                in_vld_i[vec_tab[i + k].in_port] = 1'b1;
                in_pkt_i[vec_tab[i + k].in_port] = vec_tab[i + k].pkt;
            end

            // hold valid until each input has transferred
            while (in_vld_i != '0) begin
                @(negedge clk);
                acc = in_vld_i & in_rdy_o;
                if (acc != '0) xfer_cyc = cyc;   // cycle ending in the transfer edge
                @(posedge clk);
                #1;
                in_vld_i = in_vld_i & ~acc;
            end

            @(negedge clk);
            while (out_vld_o == '0) @(negedge clk);
            check_port(cur_test, e, first_port(out_vld_o));
            check_lat(cur_test, 2, cyc - xfer_cyc);   // two register stages

            if (stall > 0) begin
                held    = out_pkt_o[e];
                rdy_exp = '1;
                if (n == 2) rdy_exp[vec_tab[l].in_port] = 1'b0;  // stuck behind winner
                repeat (stall) begin
                    check_pkt(cur_test, held, out_pkt_o[e]);
                    check_vec(cur_test, rdy_exp, in_rdy_o);
                    @(negedge clk);
                end
                @(posedge clk);
                #1;
                out_rdy_i[e] = 1'b1;
                @(negedge clk);
            end

            while (exp_q.size() > 0) begin
                while (!(out_vld_o[e] && out_rdy_i[e])) @(negedge clk);
                check_pkt(cur_test, exp_q.pop_front(), out_pkt_o[e]);
                @(negedge clk);
            end
            check_vec(cur_test, '0, out_vld_o);  // nothing extra left behind
            i = i + n;
        end

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+testbench
common/pkt_pkg.sv
common/route_pkg.sv
router/xy_route.sv
router/input_buf.sv
router/qos_arbiter.sv
router/crossbar.sv
router/output_buf.sv
verilog/mesh_node.sv
testbench/tb_mesh_node.sv

// ==== verilog/mesh_node.sv ====
//====================================================================
// one node of the 2D packet mesh, XY routed, five ports
// two register stages: input transfer to out_vld_o is 2 cycles with
// no contention; up to ten packets in flight inside the node
//====================================================================
`timescale 1ns/10ps

module mesh_node
    import route_pkg::*;
#(
    parameter int NODE_X = 0,
    parameter int NODE_Y = 0
) (
    input  logic           clk,
    input  logic           reset_i,
    input  port_vec_t      in_vld_i,
    input  pkt_arr_t       in_pkt_i,
    output wire port_vec_t in_rdy_o,
    output wire port_vec_t out_vld_o,
    output wire pkt_arr_t  out_pkt_o,
    input  port_vec_t      out_rdy_i
);

    wire port_vec_t                 hold_vld;    // per input
    wire pkt_arr_t                  hold_pkt;
    wire port_vec_t [NUM_PORTS-1:0] route;       // [input][output]
    wire port_vec_t                 gnt;         // per input
    wire port_vec_t                 load;        // per output
    wire pkt_arr_t                  sel_pkt;
    wire port_vec_t                 obuf_rdy;

    //==================================================================
    // input side, buffer and route unit per port
    //==================================================================
    for (genvar d = 0; d < NUM_PORTS; d++) begin : g_in
        input_buf u_ibuf (
            .clk        (clk),
            .reset_i    (reset_i),
            .vld_i      (in_vld_i[d]),
            .pkt_i      (in_pkt_i[d]),
            .rdy_o      (in_rdy_o[d]),
            .gnt_i      (gnt[d]),
            .hold_vld_o (hold_vld[d]),
            .hold_pkt_o (hold_pkt[d])
        );

        xy_route #(
            .NODE_X (NODE_X),
            .NODE_Y (NODE_Y)
        ) u_route (
            .tgt_i   (hold_pkt[d].tgt),
            .route_o (route[d])
        );
    end

    crossbar u_xbar (
        .hold_vld_i (hold_vld),
        .hold_pkt_i (hold_pkt),
        .route_i    (route),
        .obuf_rdy_i (obuf_rdy),
        .gnt_o      (gnt),
        .load_o     (load),
        .sel_pkt_o  (sel_pkt)
    );

    //==================================================================
    // output registers
    //==================================================================
    for (genvar d = 0; d < NUM_PORTS; d++) begin : g_out
        output_buf u_obuf (
            .clk     (clk),
            .reset_i (reset_i),
            .load_i  (load[d]),
            .pkt_i   (sel_pkt[d]),
            .rdy_o   (obuf_rdy[d]),
            .vld_o   (out_vld_o[d]),
            .pkt_o   (out_pkt_o[d]),
            .rdy_i   (out_rdy_i[d])
        );
    end

endmodule
